// ==== miss_cfg_pkg.sv ====
// miss entry widths, entry field positions and vector types
package miss_cfg_pkg;

  // miss address and the cache block inside it
  localparam int addr_width_c = 32;
  localparam int block_offset_c = 4;

  // sequence id given to each accepted miss
  localparam int id_width_c = 8;

  // one fifo entry is {addr, id, prefetch}
  localparam int entry_width_c = addr_width_c + id_width_c + 1;

  localparam int entry_pf_bit_c = 0;
  localparam int entry_id_lsb_c = 1;
  localparam int entry_addr_lsb_c = id_width_c + 1;

  typedef logic [addr_width_c-1:0] addr_t;
  typedef logic [id_width_c-1:0] id_t;

endpackage

// ==== miss_op_pkg.sv ====
// miss fifo operation and miss handler state encodings
package miss_op_pkg;

  // how the consumer takes the presented entry
  //   op_dequeue    remove the entry, release the checkpoint when it is the oldest
  //   op_skip       leave the entry queued, move on
  //   op_invalidate remove the entry, keep it under the checkpoint
  typedef enum logic [1:0] {
    op_dequeue,
    op_skip,
    op_invalidate
  } fifo_op_e;

  // batch forming states of the handler
  typedef enum logic [1:0] {
    st_idle,
    st_scan,
    st_rollback
  } handler_state_e;

endpackage

// ==== miss_collector.sv ====
// miss collector: registers miss strobes, tags them with ids and counts drops
`timescale 1ns/1ps

module miss_collector (
  input  logic clk_i,
  input  logic reset_i,

  input  logic req_v_i,
  input  miss_cfg_pkg::addr_t req_addr_i,
  input  logic req_prefetch_i,

  input  logic fifo_ready_i,
  output logic fifo_v_o,
  output logic [miss_cfg_pkg::entry_width_c-1:0] fifo_data_o,

  output logic [15:0] drop_count_o
);

  logic req_v_r;
  miss_cfg_pkg::addr_t req_addr_r;
  logic req_pf_r;
  miss_cfg_pkg::id_t id_r;
  logic accept;
  logic drop;

  // the strobe is held for exactly one cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_v_r <= 1'b0;
    end else begin
      req_v_r <= req_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_v_i) begin
      req_addr_r <= req_addr_i;
      req_pf_r <= req_prefetch_i;
    end
  end

  assign accept = req_v_r & fifo_ready_i;
  assign drop = req_v_r & ~fifo_ready_i;

  // ids only go to entries the fifo took
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_r <= '0;
      drop_count_o <= '0;
    end else begin
      if (accept) begin
        id_r <= id_r + 1'b1;
      end
      if (drop) begin
        drop_count_o <= drop_count_o + 16'd1;
      end
    end
  end

  assign fifo_v_o = req_v_r;
  assign fifo_data_o = {req_addr_r, id_r, req_pf_r};

  // a dropped miss must not consume an id
  a_no_id_on_drop: assert property (
    @(posedge clk_i) disable iff (reset_i)
    drop |=> $stable(id_r)
  ) else $error("miss_collector: id counter moved on a dropped request");

endmodule

// ==== miss_fifo.sv ====
// miss fifo: valid-bit slots, read/write/checkpoint pointers, scan ops, rollback
`timescale 1ns/1ps

module miss_fifo #(
  parameter int depth_p = 8
) (
  input  logic clk_i,
  input  logic reset_i,

  input  logic [miss_cfg_pkg::entry_width_c-1:0] data_i,
  input  logic v_i,
  output logic ready_o,

  output logic v_o,
  output logic [miss_cfg_pkg::entry_width_c-1:0] data_o,
  input  logic yumi_i,
  input  miss_op_pkg::fifo_op_e yumi_op_i,
  input  logic scan_not_dq_i,

  output logic empty_o,
  input  logic rollback_i
);

  localparam int ptr_width_lp = $clog2(depth_p);
  localparam int width_lp = miss_cfg_pkg::entry_width_c;

  logic [depth_p-1:0] valid_r, valid_n;
  logic [ptr_width_lp-1:0] rptr_r, rptr_n, wptr_r, cptr_r;
  logic [ptr_width_lp-1:0] rptr_plus1, rptr_plus2;
  logic rptr_valid, rptr_plus1_valid, rptr_plus2_valid, cptr_valid;
  logic at_cptr, rw_same, read_ahead;

  logic [width_lp-1:0] mem_r [depth_p];
  logic [width_lp-1:0] mem_data_r;
  logic mem_read_en, mem_read_en_r;
  logic [ptr_width_lp-1:0] mem_read_addr, mem_read_addr_r;

  logic [width_lp-1:0] data_r, data_n;
  logic v_r, v_n;

  logic enque, deque, inval, cptr_inc;
  logic enque_r, deque_r;
  logic full, empty, can_step;

  assign rptr_plus1 = rptr_r + ptr_width_lp'(1);
  assign rptr_plus2 = rptr_r + ptr_width_lp'(2);

  assign rptr_valid = valid_r[rptr_r];
  assign rptr_plus1_valid = valid_r[rptr_plus1];
  assign rptr_plus2_valid = valid_r[rptr_plus2];
  assign cptr_valid = valid_r[cptr_r];

  assign at_cptr = (rptr_r == cptr_r);
  assign rw_same = (rptr_plus1 == wptr_r);
  // next slot already fetched into the read register
  assign read_ahead = mem_read_en_r & (rptr_plus1 == mem_read_addr_r);

  // last pointer event tells full from empty when pointers meet
  assign full = enque_r & (cptr_r == wptr_r);
  assign empty = deque_r & (rptr_r == wptr_r);
  // a full queue of dead slots still has to be stepped through
  assign can_step = ~empty | (full & ~scan_not_dq_i);

  assign ready_o = ~full;
  assign empty_o = empty;
  assign enque = v_i & ready_o;

  assign v_o = v_r;
  assign data_o = data_r;

  // inferred 1r1w memory, synchronous read
  always_ff @(posedge clk_i) begin
    if (enque) begin
      mem_r[wptr_r] <= data_i;
    end
    if (mem_read_en) begin
      mem_data_r <= mem_r[mem_read_addr];
    end
  end

  always_comb begin
    valid_n = valid_r;
    if (enque) begin
      valid_n[wptr_r] = 1'b1;
    end
    if (inval) begin
      valid_n[rptr_r] = 1'b0;
    end
  end

  always_comb begin
    deque = 1'b0;
    inval = 1'b0;
    cptr_inc = 1'b0;
    rptr_n = rptr_r;
    mem_read_en = 1'b0;
    mem_read_addr = rptr_r;
    v_n = v_r;
    data_n = data_r;

    if (rollback_i) begin
      rptr_n = cptr_r;
      mem_read_en = cptr_valid;
      mem_read_addr = cptr_r;
    end else if (v_r) begin
      if (yumi_i) begin
        case (yumi_op_i)
          miss_op_pkg::op_dequeue: begin
            deque = 1'b1;
            inval = 1'b1;
            cptr_inc = at_cptr;
          end
          miss_op_pkg::op_skip: begin
            deque = 1'b1;
          end
          miss_op_pkg::op_invalidate: begin
            deque = 1'b1;
            inval = 1'b1;
          end
          default: begin
            deque = 1'b0;
          end
        endcase
        if (deque) begin
          rptr_n = rptr_plus1;
          mem_read_addr = read_ahead ? rptr_plus2 : rptr_plus1;
          mem_read_en = ~rw_same & (read_ahead ? rptr_plus2_valid : rptr_plus1_valid);
          v_n = rw_same ? enque : mem_read_en_r;
          if (rw_same) begin
            data_n = enque ? data_i : data_r;
          end else begin
            data_n = mem_read_en_r ? mem_data_r : data_r;
          end
        end
      end else begin
        // holding the head, fetch the one behind it
        mem_read_en = rptr_plus1_valid;
        mem_read_addr = rptr_plus1;
      end
    end else begin
      // step over slots removed earlier
      if (can_step && !rptr_valid) begin
        deque = 1'b1;
        cptr_inc = ~scan_not_dq_i;
        rptr_n = rptr_plus1;
      end
      mem_read_en = mem_read_en_r ? rptr_plus1_valid : rptr_valid;
      mem_read_addr = mem_read_en_r ? rptr_plus1 : rptr_r;
      v_n = empty ? enque : mem_read_en_r;
      if (empty) begin
        data_n = enque ? data_i : data_r;
      end else begin
        data_n = mem_read_en_r ? mem_data_r : data_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
      rptr_r <= '0;
      wptr_r <= '0;
      cptr_r <= '0;
      v_r <= 1'b0;
      mem_read_en_r <= 1'b0;
      mem_read_addr_r <= '0;
      enque_r <= 1'b0;
      deque_r <= 1'b1;
    end else begin
      valid_r <= valid_n;
      rptr_r <= rptr_n;
      if (enque) begin
        wptr_r <= wptr_r + ptr_width_lp'(1);
      end
      if (cptr_inc) begin
        cptr_r <= cptr_r + ptr_width_lp'(1);
      end
      v_r <= v_n;
      mem_read_en_r <= mem_read_en;
      if (mem_read_en) begin
        mem_read_addr_r <= mem_read_addr;
      end
      if (cptr_inc | enque) begin
        enque_r <= enque;
      end
      // after rollback the queue is empty only if no slot is live
      if (rollback_i) begin
        deque_r <= ~|valid_r;
      end else if (enque | deque) begin
        deque_r <= deque;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    data_r <= data_n;
  end

  a_rollback_when_empty: assert property (
    @(posedge clk_i) disable iff (reset_i)
    rollback_i |-> empty_o
  ) else $error("miss_fifo: rollback while not empty");

  // enqueue never lands on a live entry
  a_no_overwrite: assert property (
    @(posedge clk_i) disable iff (reset_i)
    enque |-> !valid_r[wptr_r]
  ) else $error("miss_fifo: enqueue into an occupied slot");

  a_yumi_on_valid: assert property (
    @(posedge clk_i) disable iff (reset_i)
    yumi_i |-> v_o
  ) else $error("miss_fifo: yumi without valid output");

endmodule

// ==== miss_handler.sv ====
// miss handler: forms one batch per cache block and issues its demand misses
`timescale 1ns/1ps

module miss_handler (
  input  logic clk_i,
  input  logic reset_i,

  input  logic fifo_v_i,
  input  logic [miss_cfg_pkg::entry_width_c-1:0] fifo_data_i,
  input  logic fifo_empty_i,
  output logic fifo_yumi_o,
  output miss_op_pkg::fifo_op_e fifo_op_o,
  output logic scan_mode_o,
  output logic rollback_o,

  output logic serve_v_o,
  output miss_cfg_pkg::addr_t serve_addr_o,
  output miss_cfg_pkg::id_t serve_id_o,
  output logic batch_start_o
);

  miss_op_pkg::handler_state_e state_r, state_n;

  logic [miss_cfg_pkg::addr_width_c-1:miss_cfg_pkg::block_offset_c] block_r;
  miss_cfg_pkg::addr_t entry_addr;
  miss_cfg_pkg::id_t entry_id;
  logic entry_pf;
  logic same_block;
  logic issue;
  logic start;

  // entry fields
  assign entry_addr = fifo_data_i[miss_cfg_pkg::entry_addr_lsb_c +: miss_cfg_pkg::addr_width_c];
  assign entry_id = fifo_data_i[miss_cfg_pkg::entry_id_lsb_c +: miss_cfg_pkg::id_width_c];
  assign entry_pf = fifo_data_i[miss_cfg_pkg::entry_pf_bit_c];

  assign same_block =
    (entry_addr[miss_cfg_pkg::addr_width_c-1:miss_cfg_pkg::block_offset_c] == block_r);

  // fifo stays in scan mode until the batch is rolled back
  assign scan_mode_o = (state_r != miss_op_pkg::st_idle);

  always_comb begin
    state_n = state_r;
    fifo_yumi_o = 1'b0;
    fifo_op_o = miss_op_pkg::op_dequeue;
    rollback_o = 1'b0;
    issue = 1'b0;
    start = 1'b0;

    case (state_r)
      miss_op_pkg::st_idle: begin
        // head entry opens the batch
        if (fifo_v_i) begin
          fifo_yumi_o = 1'b1;
          fifo_op_o = miss_op_pkg::op_dequeue;
          issue = ~entry_pf;
          start = 1'b1;
          state_n = miss_op_pkg::st_scan;
        end
      end
      miss_op_pkg::st_scan: begin
        if (fifo_v_i) begin
          fifo_yumi_o = 1'b1;
          if (same_block) begin
            // the fill covers a prefetch of this block
            fifo_op_o = entry_pf ? miss_op_pkg::op_invalidate : miss_op_pkg::op_dequeue;
            issue = ~entry_pf;
          end else begin
            fifo_op_o = miss_op_pkg::op_skip;
          end
        end else if (fifo_empty_i) begin
          state_n = miss_op_pkg::st_rollback;
        end
      end
      miss_op_pkg::st_rollback: begin
        // a late enqueue reopens the scan first
        if (fifo_empty_i) begin
          rollback_o = 1'b1;
          state_n = miss_op_pkg::st_idle;
        end else begin
          state_n = miss_op_pkg::st_scan;
        end
      end
      default: begin
        state_n = miss_op_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= miss_op_pkg::st_idle;
      serve_v_o <= 1'b0;
      batch_start_o <= 1'b0;
    end else begin
      state_r <= state_n;
      serve_v_o <= issue;
      batch_start_o <= start;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start) begin
      block_r <= entry_addr[miss_cfg_pkg::addr_width_c-1:miss_cfg_pkg::block_offset_c];
    end
    if (issue | start) begin
      serve_addr_o <= entry_addr;
      serve_id_o <= entry_id;
    end
  end

  // prefetch entries are consumed silently
  a_no_prefetch_served: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (fifo_yumi_o && entry_pf) |=> !serve_v_o
  ) else $error("miss_handler: prefetch entry issued on serve port");

endmodule

// ==== miss_unit_top.sv ====
// miss unit top: collector, miss fifo and handler wired together
`timescale 1ns/1ps

module miss_unit_top #(
  parameter int depth_p = 8,
  parameter int addr_width_p = miss_cfg_pkg::addr_width_c
) (
  input  logic clk_i,
  input  logic reset_i,

  input  logic req_v_i,
  input  logic [addr_width_p-1:0] req_addr_i,
  input  logic req_prefetch_i,

  output logic serve_v_o,
  output logic [addr_width_p-1:0] serve_addr_o,
  output miss_cfg_pkg::id_t serve_id_o,
  output logic batch_start_o,
  output logic [15:0] drop_count_o
);

  logic fifo_v;
  logic [miss_cfg_pkg::entry_width_c-1:0] fifo_data;
  logic fifo_ready;
  logic fifo_out_v;
  logic [miss_cfg_pkg::entry_width_c-1:0] fifo_out_data;
  logic fifo_yumi;
  miss_op_pkg::fifo_op_e fifo_op;
  logic scan_mode;
  logic fifo_empty;
  logic rollback;

  // entry layout carries a fixed address field
  if (addr_width_p != miss_cfg_pkg::addr_width_c) begin : g_addr_width_check
    $error("miss_unit_top: addr_width_p must equal the entry address width");
  end

  miss_collector collector_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_v_i       (req_v_i),
    .req_addr_i    (req_addr_i),
    .req_prefetch_i(req_prefetch_i),
    .fifo_ready_i  (fifo_ready),
    .fifo_v_o      (fifo_v),
    .fifo_data_o   (fifo_data),
    .drop_count_o  (drop_count_o)
  );

  miss_fifo #(
    .depth_p(depth_p)
  ) fifo_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .data_i       (fifo_data),
    .v_i          (fifo_v),
    .ready_o      (fifo_ready),
    .v_o          (fifo_out_v),
    .data_o       (fifo_out_data),
    .yumi_i       (fifo_yumi),
    .yumi_op_i    (fifo_op),
    .scan_not_dq_i(scan_mode),
    .empty_o      (fifo_empty),
    .rollback_i   (rollback)
  );

  miss_handler handler_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fifo_v_i     (fifo_out_v),
    .fifo_data_i  (fifo_out_data),
    .fifo_empty_i (fifo_empty),
    .fifo_yumi_o  (fifo_yumi),
    .fifo_op_o    (fifo_op),
    .scan_mode_o  (scan_mode),
    .rollback_o   (rollback),
    .serve_v_o    (serve_v_o),
    .serve_addr_o (serve_addr_o),
    .serve_id_o   (serve_id_o),
    .batch_start_o(batch_start_o)
  );

endmodule

// ==== tb_miss_unit.sv ====
// testbench for the miss unit: random misses, reference model, checks, watchdog, report
`timescale 1ns/1ps

module tb_miss_unit;

  localparam int depth_c = 8;
  localparam int num_req_c = 200;
  localparam int timeout_cycles_c = 200 * num_req_c + 2000;
  localparam logic [31:0] base_addr_c = 32'h8000_1000;

  logic clk_i = 1'b0;
  logic reset_i;
  logic req_v_i;
  miss_cfg_pkg::addr_t req_addr_i;
  logic req_prefetch_i;
  logic serve_v_o;
  miss_cfg_pkg::addr_t serve_addr_o;
  miss_cfg_pkg::id_t serve_id_o;
  logic batch_start_o;
  logic [15:0] drop_count_o;

  // every request seen on the input, in order
  miss_cfg_pkg::addr_t req_addr_q[$];
  logic req_pf_q[$];

  // accepted entries, indexed by id
  miss_cfg_pkg::addr_t acc_addr [256];
  logic acc_pf [256];
  logic acc_served [256];
  int accepted_count;
  int accepted_demand;
  int served_count;
  int error_count;
  int last_id [4];

  // requests still waiting for the drop counter to settle
  logic stage1_v;
  logic stage2_v;
  int stage1_idx;
  int stage2_idx;
  logic [15:0] drop_seen;

  logic batch_open;
  logic [27:0] batch_blk;
  int batch_limit;
  int batch_count;
  int serve_id;
  int serve_blk;
  int seed_val;

  miss_unit_top #(
    .depth_p(depth_c)
  ) dut_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_v_i       (req_v_i),
    .req_addr_i    (req_addr_i),
    .req_prefetch_i(req_prefetch_i),
    .serve_v_o     (serve_v_o),
    .serve_addr_o  (serve_addr_o),
    .serve_id_o    (serve_id_o),
    .batch_start_o (batch_start_o),
    .drop_count_o  (drop_count_o)
  );

  always #50 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("ERROR: %s expected %0h actual %0h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic drive_random_request();
    logic [1:0] blk;
    logic [3:0] off;
    blk = $urandom % 4;
    off = $urandom % 16;
    @(posedge clk_i);
    #5;
    req_v_i = 1'b1;
    req_addr_i = base_addr_c + {blk, off};
    req_prefetch_i = (($urandom % 4) == 0);
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      #5;
      req_v_i = 1'b0;
    end
  endtask

  // every demand entry of the closed batch's block, queued at its start, is served
  task automatic check_batch_drained();
    int i;
    for (i = 0; i < batch_limit; i++) begin
      if (acc_addr[i][31:4] == batch_blk && !acc_pf[i]) begin
        check_value("batch left demand entry", 1, acc_served[i]);
      end
    end
  endtask

  task finish_run();
    $display("errors: %0d  requests: %0d  accepted: %0d  dropped: %0d  served: %0d  batches: %0d",
             error_count, req_addr_q.size(), accepted_count, drop_count_o, served_count,
             batch_count);
    if (error_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // reference model, sampled at the falling edge where outputs are stable
  always @(negedge clk_i) begin
    if (reset_i) begin
      check_value("serve_v_o in reset", 0, serve_v_o);
      check_value("batch_start_o in reset", 0, batch_start_o);
      check_value("drop_count_o in reset", 0, drop_count_o);
      stage1_v = 1'b0;
      stage2_v = 1'b0;
      drop_seen = '0;
    end else begin
      // a request two edges old is now either dropped or holds the next id
      if (stage2_v) begin
        if (drop_count_o == drop_seen + 16'd1) begin
          drop_seen = drop_count_o;
        end else begin
          acc_addr[accepted_count] = req_addr_q[stage2_idx];
          acc_pf[accepted_count] = req_pf_q[stage2_idx];
          acc_served[accepted_count] = 1'b0;
          if (!req_pf_q[stage2_idx]) begin
            accepted_demand++;
          end
          accepted_count++;
        end
      end
      check_value("drop count", drop_seen, drop_count_o);

      if (batch_start_o) begin
        if (batch_open) begin
          check_batch_drained();
        end
        check_value("batch head accepted", 1, serve_id_o < accepted_count);
        if (serve_id_o < accepted_count) begin
          check_value("batch head address", acc_addr[serve_id_o], serve_addr_o);
        end
        batch_open = 1'b1;
        batch_blk = serve_addr_o[31:4];
        batch_limit = accepted_count;
        batch_count++;
      end

      if (serve_v_o) begin
        serve_id = serve_id_o;
        check_value("served id accepted", 1, serve_id < accepted_count);
        check_value("serve inside batch", 1, batch_open);
        if (serve_id < accepted_count) begin
          check_value("serve address", acc_addr[serve_id], serve_addr_o);
          check_value("served entry is demand", 0, acc_pf[serve_id]);
          check_value("id served once", 0, acc_served[serve_id]);
          check_value("serve block in batch", batch_blk, serve_addr_o[31:4]);
          acc_served[serve_id] = 1'b1;
          served_count++;
          serve_blk = serve_addr_o[5:4];
          if (last_id[serve_blk] >= 0) begin
            check_value("id order in block", 1, serve_id > last_id[serve_blk]);
          end
          last_id[serve_blk] = serve_id;
        end
      end

      stage2_v = stage1_v;
      stage2_idx = stage1_idx;
      stage1_v = req_v_i;
      if (req_v_i) begin
        req_addr_q.push_back(req_addr_i);
        req_pf_q.push_back(req_prefetch_i);
        stage1_idx = req_addr_q.size() - 1;
      end
    end
  end

  initial begin : watchdog
    repeat (timeout_cycles_c) @(posedge clk_i);
    error_count++;
    $display("ERROR: timeout, the unit did not drain within %0d cycles", timeout_cycles_c);
    finish_run();
  end

  initial begin : main
    int sent;
    int burst_len;
    int i;
    seed_val = $urandom(81);
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_addr_i = '0;
    req_prefetch_i = 1'b0;
    accepted_count = 0;
    accepted_demand = 0;
    served_count = 0;
    error_count = 0;
    batch_open = 1'b0;
    batch_blk = '0;
    batch_limit = 0;
    batch_count = 0;
    for (i = 0; i < 4; i++) begin
      last_id[i] = -1;
    end

    repeat (4) @(posedge clk_i);
    #5;
    reset_i = 1'b0;

    // quiet after reset
    repeat (4) begin
      @(negedge clk_i);
      check_value("serve_v_o after reset", 0, serve_v_o);
      check_value("batch_start_o after reset", 0, batch_start_o);
      check_value("drop_count_o after reset", 0, drop_count_o);
    end

    // back-to-back bursts overrun the fifo
    sent = 0;
    while (sent < num_req_c) begin
      burst_len = 4 + ($urandom % 21);
      for (i = 0; i < burst_len && sent < num_req_c; i++) begin
        drive_random_request();
        sent++;
      end
      drive_idle(5 + ($urandom % 30));
    end

    while (stage1_v || stage2_v || served_count != accepted_demand) begin
      @(posedge clk_i);
    end
    // late duplicates would still show up here
    repeat (20) @(posedge clk_i);

    if (batch_open) begin
      check_batch_drained();
    end
    for (i = 0; i < accepted_count; i++) begin
      if (!acc_pf[i]) begin
        check_value("demand id served", 1, acc_served[i]);
      end
    end
    check_value("served count", accepted_demand, served_count);
    check_value("requests conserved", req_addr_q.size(), drop_count_o + accepted_count);
    finish_run();
  end

endmodule

// ==== flist.f ====
miss_cfg_pkg.sv
miss_op_pkg.sv
miss_collector.sv
miss_fifo.sv
miss_handler.sv
miss_unit_top.sv
tb_miss_unit.sv

// ==== Bender.yml ====
package:
  name: miss_unit

sources:
  - miss_cfg_pkg.sv
  - miss_op_pkg.sv
  - miss_collector.sv
  - miss_fifo.sv
  - miss_handler.sv
  - miss_unit_top.sv
  - target: test
    files:
      - tb_miss_unit.sv
